// File: axi_gpio.sv
/*
  axi4-lite gpio output register
  byte strobe writes, read back, low byte on csr_o
*/

module axi_gpio (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  nox_lite_pkg::s_axil_req_t  axi_req_i,
  output nox_lite_pkg::s_axil_resp_t axi_resp_o,
  output logic [7:0]                 csr_o
);
  import nox_lite_pkg::*;

  logic [DATA_W-1:0] gpio_q;
  logic [DATA_W-1:0] rdata_q;
  logic              bvalid_q, rvalid_q;
  logic              wr_fire, rd_fire;

  assign wr_fire = axi_req_i.awvalid & axi_req_i.wvalid & ~bvalid_q;
  assign rd_fire = axi_req_i.arvalid & ~rvalid_q;

  always_comb begin
    axi_resp_o         = '0;
    axi_resp_o.awready = wr_fire;
    axi_resp_o.wready  = wr_fire;
    axi_resp_o.bvalid  = bvalid_q;
    axi_resp_o.bresp   = RESP_OKAY;
    axi_resp_o.arready = rd_fire;
    axi_resp_o.rvalid  = rvalid_q;
    axi_resp_o.rresp   = RESP_OKAY;
    axi_resp_o.rdata   = rdata_q;
  end

  // outputs low out of reset
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      gpio_q   <= '0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (axi_req_i.wstrb[b])
            gpio_q[8*b +: 8] <= axi_req_i.wdata[8*b +: 8];
        end
      end
      if (wr_fire)
        bvalid_q <= 1'b1;
      else if (axi_req_i.bready)
        bvalid_q <= 1'b0;
      if (rd_fire)
        rvalid_q <= 1'b1;
      else if (axi_req_i.rready)
        rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire)
      rdata_q <= gpio_q;
  end

  assign csr_o = gpio_q[7:0];

endmodule

// File: axi_lite_xbar.sv
/*
  single master axi4-lite interconnect
  address decode on the top nibble, request fan-out,
  response steering by stored slave index, decerr for holes
*/

module axi_lite_xbar (
  input  logic                                               clk,
  input  logic                                               rst_n_i,
  input  nox_lite_pkg::s_axil_req_t                          m_req_i,
  output nox_lite_pkg::s_axil_resp_t                         m_resp_o,
  output nox_lite_pkg::s_axil_req_t  [nox_lite_pkg::N_SLAVES-1:0] s_req_o,
  input  nox_lite_pkg::s_axil_resp_t [nox_lite_pkg::N_SLAVES-1:0] s_resp_i
);
  import nox_lite_pkg::*;

  // returns {hit, slave index}
  function automatic logic [2:0] decode_slv(input logic [ADDR_W-1:0] addr);
    logic [2:0] sel;
    case (addr[ADDR_W-1 -: 4])
      ROM_BASE[ADDR_W-1 -: 4]:  sel = {1'b1, SLV_ROM};
      DRAM_BASE[ADDR_W-1 -: 4]: sel = {1'b1, SLV_DRAM};
      RST_BASE[ADDR_W-1 -: 4]:  sel = {1'b1, SLV_RST};
      GPIO_BASE[ADDR_W-1 -: 4]: sel = {1'b1, SLV_GPIO};
      default:                  sel = 3'b000;
    endcase
    return sel;
  endfunction

  logic       aw_hit, ar_hit;
  logic [1:0] aw_idx, ar_idx;
  logic       aw_fire, b_fire, ar_fire, r_fire;

  // one outstanding transaction per direction
  logic       wr_pend_q, rd_pend_q;
  logic [1:0] wr_idx_q, rd_idx_q;
  logic       wr_err_q, rd_err_q;

  assign {aw_hit, aw_idx} = decode_slv(m_req_i.awaddr);
  assign {ar_hit, ar_idx} = decode_slv(m_req_i.araddr);

  // request fan-out, payload goes everywhere, valids only to the target
  always_comb begin
    for (int i = 0; i < N_SLAVES; i++) begin
      s_req_o[i]         = m_req_i;
      s_req_o[i].awvalid = 1'b0;
      s_req_o[i].wvalid  = 1'b0;
      s_req_o[i].bready  = 1'b0;
      s_req_o[i].arvalid = 1'b0;
      s_req_o[i].rready  = 1'b0;
    end
    if (!wr_pend_q && aw_hit) begin
      s_req_o[aw_idx].awvalid = m_req_i.awvalid;
      s_req_o[aw_idx].wvalid  = m_req_i.wvalid;
    end
    if (wr_pend_q && !wr_err_q)
      s_req_o[wr_idx_q].bready = m_req_i.bready;
    if (!rd_pend_q && ar_hit)
      s_req_o[ar_idx].arvalid = m_req_i.arvalid;
    if (rd_pend_q && !rd_err_q)
      s_req_o[rd_idx_q].rready = m_req_i.rready;
  end

  // write side readies and response
  always_comb begin
    m_resp_o = '0;
    if (!wr_pend_q) begin
      if (aw_hit) begin
        m_resp_o.awready = s_resp_i[aw_idx].awready;
        m_resp_o.wready  = s_resp_i[aw_idx].wready;
      end else begin
        // hole in the map, take it here
        m_resp_o.awready = m_req_i.awvalid & m_req_i.wvalid;
        m_resp_o.wready  = m_req_i.awvalid & m_req_i.wvalid;
      end
    end else if (wr_err_q) begin
      m_resp_o.bvalid = 1'b1;
      m_resp_o.bresp  = RESP_DECERR;
    end else begin
      m_resp_o.bvalid = s_resp_i[wr_idx_q].bvalid;
      m_resp_o.bresp  = s_resp_i[wr_idx_q].bresp;
    end
    // read side
    if (!rd_pend_q) begin
      m_resp_o.arready = ar_hit ? s_resp_i[ar_idx].arready : m_req_i.arvalid;
    end else if (rd_err_q) begin
      m_resp_o.rvalid = 1'b1;
      m_resp_o.rresp  = RESP_DECERR;
    end else begin
      m_resp_o.rvalid = s_resp_i[rd_idx_q].rvalid;
      m_resp_o.rresp  = s_resp_i[rd_idx_q].rresp;
      m_resp_o.rdata  = s_resp_i[rd_idx_q].rdata;
    end
  end

  assign aw_fire = m_req_i.awvalid & m_req_i.wvalid & m_resp_o.awready;
  assign b_fire  = m_resp_o.bvalid & m_req_i.bready;
  assign ar_fire = m_req_i.arvalid & m_resp_o.arready;
  assign r_fire  = m_resp_o.rvalid & m_req_i.rready;

  // pending flags
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_pend_q <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      if (aw_fire)
        wr_pend_q <= 1'b1;
      else if (b_fire)
        wr_pend_q <= 1'b0;
      if (ar_fire)
        rd_pend_q <= 1'b1;
      else if (r_fire)
        rd_pend_q <= 1'b0;
    end
  end

  // routing info, only looked at while pending
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_idx_q <= aw_idx;
      wr_err_q <= ~aw_hit;
    end
    if (ar_fire) begin
      rd_idx_q <= ar_idx;
      rd_err_q <= ~ar_hit;
    end
  end

endmodule

// File: axi_mem.sv
/*
  axi4-lite data ram
  byte strobe writes, one cycle read, size set by MEM_KB,
  addresses wrap inside the array
*/

module axi_mem #(
  parameter int MEM_KB = 8
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  nox_lite_pkg::s_axil_req_t  axi_req_i,
  output nox_lite_pkg::s_axil_resp_t axi_resp_o
);
  import nox_lite_pkg::*;

  // 256 words per kbyte
  localparam int MEM_WORDS = MEM_KB * 256;
  localparam int IDX_W     = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]  wr_idx, rd_idx;
  logic              bvalid_q, rvalid_q;
  logic              wr_fire, rd_fire;

  // upper address bits dropped, so it wraps
  assign wr_idx = axi_req_i.awaddr[IDX_W+1:2];
  assign rd_idx = axi_req_i.araddr[IDX_W+1:2];

  assign wr_fire = axi_req_i.awvalid & axi_req_i.wvalid & ~bvalid_q;
  assign rd_fire = axi_req_i.arvalid & ~rvalid_q;

  always_comb begin
    axi_resp_o         = '0;
    axi_resp_o.awready = wr_fire;
    axi_resp_o.wready  = wr_fire;
    axi_resp_o.bvalid  = bvalid_q;
    axi_resp_o.bresp   = RESP_OKAY;
    axi_resp_o.arready = rd_fire;
    axi_resp_o.rvalid  = rvalid_q;
    axi_resp_o.rresp   = RESP_OKAY;
    axi_resp_o.rdata   = rdata_q;
  end

  // handshake state
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire)
        bvalid_q <= 1'b1;
      else if (axi_req_i.bready)
        bvalid_q <= 1'b0;
      if (rd_fire)
        rvalid_q <= 1'b1;
      else if (axi_req_i.rready)
        rvalid_q <= 1'b0;
    end
  end

  // storage, per byte lane
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (axi_req_i.wstrb[b])
          mem[wr_idx][8*b +: 8] <= axi_req_i.wdata[8*b +: 8];
      end
    end
    if (rd_fire)
      rdata_q <= mem[rd_idx];
  end

endmodule

// File: axi_rom.sv
/*
  axi4-lite boot rom
  contents from boot_rom.hex, reads okay, writes slverr
*/

module axi_rom (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  nox_lite_pkg::s_axil_req_t  axi_req_i,
  output nox_lite_pkg::s_axil_resp_t axi_resp_o
);
  import nox_lite_pkg::*;

  logic [DATA_W-1:0] rom [ROM_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic              bvalid_q, rvalid_q;
  logic              wr_fire, rd_fire;

  initial begin
    $readmemh("boot_rom.hex", rom);
  end

  // accept only when the previous response is gone
  assign wr_fire = axi_req_i.awvalid & axi_req_i.wvalid & ~bvalid_q;
  assign rd_fire = axi_req_i.arvalid & ~rvalid_q;

  always_comb begin
    axi_resp_o         = '0;
    axi_resp_o.awready = wr_fire;
    axi_resp_o.wready  = wr_fire;
    axi_resp_o.bvalid  = bvalid_q;
    axi_resp_o.bresp   = RESP_SLVERR;   // read-only
    axi_resp_o.arready = rd_fire;
    axi_resp_o.rvalid  = rvalid_q;
    axi_resp_o.rresp   = RESP_OKAY;
    axi_resp_o.rdata   = rdata_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire)
        bvalid_q <= 1'b1;
      else if (axi_req_i.bready)
        bvalid_q <= 1'b0;
      if (rd_fire)
        rvalid_q <= 1'b1;
      else if (axi_req_i.rready)
        rvalid_q <= 1'b0;
    end
  end

  // word select on bits 5:2
  always_ff @(posedge clk) begin
    if (rd_fire)
      rdata_q <= rom[axi_req_i.araddr[5:2]];
  end

endmodule

// File: boot_rom.hex
// boot rom image, one 32-bit word per line in hex, word 0 first
100000b7
00008067
00000013
0ff00293
d0000337
00532023
c00003b7
0003a403
00100073
0000006f
deadbeef
cafef00d
12345678
9abcdef0
a5a5c3c3
0f1e2d3c

// File: nox_lite_pkg.sv
/*
  shared definitions for the nox lite bus fabric
  bus widths, slave indices, address map, response codes,
  boot address default and the axi4-lite request/response structs
*/

package nox_lite_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // slave slots on the interconnect
  localparam int N_SLAVES = 4;

  localparam logic [1:0] SLV_ROM  = 2'd0;
  localparam logic [1:0] SLV_DRAM = 2'd1;
  localparam logic [1:0] SLV_RST  = 2'd2;
  localparam logic [1:0] SLV_GPIO = 2'd3;

  // address map, only the top nibble is decoded
  localparam logic [ADDR_W-1:0] ROM_BASE  = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] DRAM_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] RST_BASE  = 32'hC000_0000;
  localparam logic [ADDR_W-1:0] GPIO_BASE = 32'hD000_0000;

  // boot rom depth in words
  localparam int ROM_WORDS = 16;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // core boot address after reset or bootloader request
  localparam logic [ADDR_W-1:0] BOOT_ADDR_RST = 32'h1000_0000;

  // master to slave
  typedef struct packed {
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              bready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              rready;
  } s_axil_req_t;

  // slave to master
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
    logic              rvalid;
  } s_axil_resp_t;

endpackage

// File: nox_soc.f
nox_lite_pkg.sv
axi_lite_xbar.sv
axi_rom.sv
axi_mem.sv
rst_ctrl.sv
axi_gpio.sv
nox_soc.sv
nox_soc_checker.sv
tb_nox_soc.sv

// File: nox_soc.sv
/*
  nox lite soc top
  external master into the axi4-lite interconnect,
  boot rom, data ram, reset control and gpio slaves
*/

module nox_soc (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            bootloader_i,
  input  nox_lite_pkg::s_axil_req_t       m_axi_req_i,
  output nox_lite_pkg::s_axil_resp_t      m_axi_resp_o,
  output logic [7:0]                      csr_o,
  output logic [nox_lite_pkg::ADDR_W-1:0] rst_addr_o
);
  import nox_lite_pkg::*;

  // one request/response pair per slave slot
  s_axil_req_t  [N_SLAVES-1:0] slv_req;
  s_axil_resp_t [N_SLAVES-1:0] slv_resp;

  axi_lite_xbar u_xbar (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .m_req_i  (m_axi_req_i),
    .m_resp_o (m_axi_resp_o),
    .s_req_o  (slv_req),
    .s_resp_i (slv_resp)
  );

  axi_rom u_rom (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .axi_req_i  (slv_req[SLV_ROM]),
    .axi_resp_o (slv_resp[SLV_ROM])
  );

  // 8 KB data ram
  axi_mem #(
    .MEM_KB(8)
  ) u_dram (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .axi_req_i  (slv_req[SLV_DRAM]),
    .axi_resp_o (slv_resp[SLV_DRAM])
  );

  rst_ctrl u_rst_ctrl (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .bootloader_i (bootloader_i),
    .axi_req_i    (slv_req[SLV_RST]),
    .axi_resp_o   (slv_resp[SLV_RST]),
    .rst_addr_o   (rst_addr_o)
  );

  axi_gpio u_gpio (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .axi_req_i  (slv_req[SLV_GPIO]),
    .axi_resp_o (slv_resp[SLV_GPIO]),
    .csr_o      (csr_o)
  );

endmodule

// File: nox_soc_checker.sv
/*
  bound protocol checker for the nox lite soc
  response hold, response origin, one cycle latency, reset state
*/

module nox_soc_checker (
  input logic                              clk,
  input logic                              rst_n_i,
  input logic                              bootloader_i,
  input nox_lite_pkg::s_axil_req_t         req_i,
  input nox_lite_pkg::s_axil_resp_t        resp_i,
  input logic [7:0]                        csr_i,
  input logic [nox_lite_pkg::ADDR_W-1:0]   rst_addr_i
);
  import nox_lite_pkg::*;

  // failure tally, read by the testbench at the end
  int   assert_fails = 0;

  logic aw_acc, ar_acc, b_wait, r_wait;

  assign aw_acc = req_i.awvalid & req_i.wvalid & resp_i.awready & resp_i.wready;
  assign ar_acc = req_i.arvalid & resp_i.arready;
  // response up but not taken yet
  assign b_wait = resp_i.bvalid & ~req_i.bready;
  assign r_wait = resp_i.rvalid & ~req_i.rready;

  b_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    b_wait |=> resp_i.bvalid && $stable(resp_i.bresp))
  else begin
    assert_fails++;
    $error("write response dropped or changed before bready");
  end

  r_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    r_wait |=> resp_i.rvalid && $stable(resp_i.rresp) && $stable(resp_i.rdata))
  else begin
    assert_fails++;
    $error("read response dropped or changed before rready");
  end

  // a response is either fresh from an accept or still stalled
  b_origin: assert property (@(posedge clk) disable iff (!rst_n_i)
    resp_i.bvalid |-> $past(aw_acc) || $past(b_wait))
  else begin
    assert_fails++;
    $error("bvalid without an accepted write");
  end

  r_origin: assert property (@(posedge clk) disable iff (!rst_n_i)
    resp_i.rvalid |-> $past(ar_acc) || $past(r_wait))
  else begin
    assert_fails++;
    $error("rvalid without an accepted read");
  end

  // one cycle latency
  b_lat: assert property (@(posedge clk) disable iff (!rst_n_i) aw_acc |=> resp_i.bvalid)
  else begin
    assert_fails++;
    $error("write response not one cycle after accept");
  end

  r_lat: assert property (@(posedge clk) disable iff (!rst_n_i) ar_acc |=> resp_i.rvalid)
  else begin
    assert_fails++;
    $error("read response not one cycle after accept");
  end

  rst_state: assert property (@(posedge clk) !rst_n_i |=> !resp_i.bvalid && !resp_i.rvalid
    && csr_i == 8'h00 && rst_addr_i == BOOT_ADDR_RST)
  else begin
    assert_fails++;
    $error("outputs not in reset state after reset");
  end

  boot_restore: assert property (@(posedge clk) bootloader_i |=> rst_addr_i == BOOT_ADDR_RST)
  else begin
    assert_fails++;
    $error("boot address not restored after bootloader request");
  end

endmodule

bind nox_soc nox_soc_checker chk0 (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .bootloader_i (bootloader_i),
  .req_i        (m_axi_req_i),
  .resp_i       (m_axi_resp_o),
  .csr_i        (csr_o),
  .rst_addr_i   (rst_addr_o)
);

// File: rst_ctrl.sv
/*
  core boot address register on axi4-lite
  any offset hits the one register, bootloader request
  or reset restores the default address
*/

module rst_ctrl (
  input  logic                                   clk,
  input  logic                                   rst_n_i,
  input  logic                                   bootloader_i,
  input  nox_lite_pkg::s_axil_req_t              axi_req_i,
  output nox_lite_pkg::s_axil_resp_t             axi_resp_o,
  output logic [nox_lite_pkg::ADDR_W-1:0]        rst_addr_o
);
  import nox_lite_pkg::*;

  logic [ADDR_W-1:0] boot_addr_q;
  logic [DATA_W-1:0] rdata_q;
  logic              bvalid_q, rvalid_q;
  logic              wr_fire, rd_fire;

  assign wr_fire = axi_req_i.awvalid & axi_req_i.wvalid & ~bvalid_q;
  assign rd_fire = axi_req_i.arvalid & ~rvalid_q;

  always_comb begin
    axi_resp_o         = '0;
    axi_resp_o.awready = wr_fire;
    axi_resp_o.wready  = wr_fire;
    axi_resp_o.bvalid  = bvalid_q;
    axi_resp_o.bresp   = RESP_OKAY;
    axi_resp_o.arready = rd_fire;
    axi_resp_o.rvalid  = rvalid_q;
    axi_resp_o.rresp   = RESP_OKAY;
    axi_resp_o.rdata   = rdata_q;
  end

  // bootloader wins over a write in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n_i || bootloader_i) begin
      boot_addr_q <= BOOT_ADDR_RST;
    end else if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (axi_req_i.wstrb[b])
          boot_addr_q[8*b +: 8] <= axi_req_i.wdata[8*b +: 8];
      end
    end
  end

  // bus handshake, plain reset only
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire)
        bvalid_q <= 1'b1;
      else if (axi_req_i.bready)
        bvalid_q <= 1'b0;
      if (rd_fire)
        rvalid_q <= 1'b1;
      else if (axi_req_i.rready)
        rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire)
      rdata_q <= boot_addr_q;
  end

  assign rst_addr_o = boot_addr_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# build the nox_soc testbench with verilator, run it, and grep the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_nox_soc -f nox_soc.f -o Vtb_nox_soc \
  || { echo "build failed"; exit 1; }

./obj_dir/Vtb_nox_soc +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -qx "Done: no errors" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

// File: tb_nox_soc.sv
/*
  testbench for the nox lite soc
  clock and reset, stimulus table, axi4-lite master tasks,
  value checks and a cycle watchdog
*/

module tb_nox_soc;
  import nox_lite_pkg::*;

  // table operations
  localparam logic [2:0] OP_WR   = 3'd0;
  localparam logic [2:0] OP_RD   = 3'd1;
  localparam logic [2:0] OP_BOOT = 3'd2;
  localparam logic [2:0] OP_RSTA = 3'd3;
  localparam logic [2:0] OP_CSR  = 3'd4;

  localparam int N_ENTRIES   = 32;
  localparam int CYCLE_LIMIT = 40 * N_ENTRIES + 200;

  typedef struct packed {
    logic [2:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
  } entry_t;

  logic         clk;
  logic         rst_n_i;
  logic         bootloader;
  s_axil_req_t  m_req;
  s_axil_resp_t m_resp;
  logic [7:0]   csr;
  logic [31:0]  rst_addr;

  entry_t       stim [N_ENTRIES];
  int           n_loaded;
  int           err_cnt;
  int           check_cnt;
  int           cycle_cnt;
  logic [31:0]  lcg_state;

  nox_soc dut0 (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .bootloader_i (bootloader),
    .m_axi_req_i  (m_req),
    .m_axi_resp_o (m_resp),
    .csr_o        (csr),
    .rst_addr_o   (rst_addr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // 0 to 3 cycles of ready back-pressure
  task automatic pick_delay(output int cycles);
    lcg_state = lcg_next(lcg_state);
    cycles = int'(lcg_state[31:30]);
  endtask

  // inputs change 2 units after the edge
  task automatic next_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    check_cnt++;
    if (got !== expected) begin
      err_cnt++;
      $display("FAIL t=%0t %s got %08h expected %08h", $time, name, got, expected);
    end
  endtask

  task automatic add_entry(input logic [2:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic [31:0] exp_data, input logic [1:0] exp_resp);
    if (n_loaded < N_ENTRIES) begin
      stim[n_loaded] = '{op, addr, data, strb, exp_data, exp_resp};
      n_loaded++;
    end else begin
      err_cnt++;
      $display("ERROR: stimulus table is full, entry dropped");
    end
  endtask

  // expected words follow boot_rom.hex and the byte strobe merge rule
  task automatic load_table();
    n_loaded = 0;
    add_entry(OP_RSTA, 32'h0,         32'h0,         4'h0, BOOT_ADDR_RST, RESP_OKAY);
    add_entry(OP_CSR,  32'h0,         32'h0,         4'h0, 32'h0,         RESP_OKAY);
    // boot rom
    add_entry(OP_RD,   32'h0000_0000, 32'h0,         4'h0, 32'h100000b7,  RESP_OKAY);
    add_entry(OP_RD,   32'h0000_0004, 32'h0,         4'h0, 32'h00008067,  RESP_OKAY);
    add_entry(OP_RD,   32'h0000_0028, 32'h0,         4'h0, 32'hdeadbeef,  RESP_OKAY);
    add_entry(OP_RD,   32'h0000_003c, 32'h0,         4'h0, 32'h0f1e2d3c,  RESP_OKAY);
    add_entry(OP_RD,   32'h0000_0040, 32'h0,         4'h0, 32'h100000b7,  RESP_OKAY);
    add_entry(OP_WR,   32'h0000_0008, 32'hffffffff,  4'hf, 32'h0,         RESP_SLVERR);
    add_entry(OP_RD,   32'h0000_0008, 32'h0,         4'h0, 32'h00000013,  RESP_OKAY);
    // data ram, full and partial strobes, wrap at 8 KB
    add_entry(OP_WR,   32'h1000_0000, 32'h11223344,  4'hf, 32'h0,         RESP_OKAY);
    add_entry(OP_WR,   32'h1000_0004, 32'h55667788,  4'hf, 32'h0,         RESP_OKAY);
    add_entry(OP_WR,   32'h1000_0000, 32'haabbccdd,  4'h5, 32'h0,         RESP_OKAY);
    add_entry(OP_RD,   32'h1000_0000, 32'h0,         4'h0, 32'h11bb33dd,  RESP_OKAY);
    add_entry(OP_WR,   32'h1000_0004, 32'hcafef00d,  4'h8, 32'h0,         RESP_OKAY);
    add_entry(OP_RD,   32'h1000_0004, 32'h0,         4'h0, 32'hca667788,  RESP_OKAY);
    add_entry(OP_WR,   32'h1000_2000, 32'h0badf00d,  4'hf, 32'h0,         RESP_OKAY);
    add_entry(OP_RD,   32'h1000_0000, 32'h0,         4'h0, 32'h0badf00d,  RESP_OKAY);
    // holes in the map
    add_entry(OP_RD,   32'h5000_0000, 32'h0,         4'h0, 32'h0,         RESP_DECERR);
    add_entry(OP_WR,   32'h5000_0000, 32'h12345678,  4'hf, 32'h0,         RESP_DECERR);
    add_entry(OP_RD,   32'hf000_0010, 32'h0,         4'h0, 32'h0,         RESP_DECERR);
    // boot address register
    add_entry(OP_WR,   32'hc000_0000, 32'h20000000,  4'hf, 32'h0,         RESP_OKAY);
    add_entry(OP_RSTA, 32'h0,         32'h0,         4'h0, 32'h20000000,  RESP_OKAY);
    add_entry(OP_RD,   32'hc000_0004, 32'h0,         4'h0, 32'h20000000,  RESP_OKAY);
    add_entry(OP_BOOT, 32'h0,         32'h0,         4'h0, 32'h0,         RESP_OKAY);
    add_entry(OP_RSTA, 32'h0,         32'h0,         4'h0, BOOT_ADDR_RST, RESP_OKAY);
    add_entry(OP_RD,   32'hc000_0000, 32'h0,         4'h0, BOOT_ADDR_RST, RESP_OKAY);
    // gpio
    add_entry(OP_WR,   32'hd000_0000, 32'ha5a55a3c,  4'hf, 32'h0,         RESP_OKAY);
    add_entry(OP_CSR,  32'h0,         32'h0,         4'h0, 32'h0000003c,  RESP_OKAY);
    add_entry(OP_RD,   32'hd000_0000, 32'h0,         4'h0, 32'ha5a55a3c,  RESP_OKAY);
    add_entry(OP_WR,   32'hd000_0000, 32'h000000c3,  4'h1, 32'h0,         RESP_OKAY);
    add_entry(OP_CSR,  32'h0,         32'h0,         4'h0, 32'h000000c3,  RESP_OKAY);
    add_entry(OP_RD,   32'hd000_0000, 32'h0,         4'h0, 32'ha5a55ac3,  RESP_OKAY);
    if (n_loaded != N_ENTRIES) begin
      err_cnt++;
      $display("ERROR: stimulus table holds %0d entries, %0d expected", n_loaded, N_ENTRIES);
    end
  endtask

  // called in a drive slot, returns in a drive slot
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] bresp);
    int   delay;
    logic done;
    m_req.awaddr  = addr;
    m_req.wdata   = data;
    m_req.wstrb   = strb;
    m_req.awvalid = 1'b1;
    m_req.wvalid  = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = m_resp.awready & m_resp.wready;
      next_slot();
    end
    m_req.awvalid = 1'b0;
    m_req.wvalid  = 1'b0;
    pick_delay(delay);
    repeat (delay) next_slot();
    m_req.bready = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done  = m_resp.bvalid;
      bresp = m_resp.bresp;
      next_slot();
    end
    m_req.bready = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic [1:0] rresp);
    int   delay;
    logic done;
    m_req.araddr  = addr;
    m_req.arvalid = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = m_resp.arready;
      next_slot();
    end
    m_req.arvalid = 1'b0;
    pick_delay(delay);
    repeat (delay) next_slot();
    m_req.rready = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done  = m_resp.rvalid;
      rdata = m_resp.rdata;
      rresp = m_resp.rresp;
      next_slot();
    end
    m_req.rready = 1'b0;
  endtask

  task automatic apply_entry(input entry_t e);
    logic [31:0] rdata;
    logic [1:0]  resp;
    case (e.op)
      OP_WR: begin
        bus_write(e.addr, e.data, e.strb, resp);
        check_val($sformatf("bresp[%08h]", e.addr), {30'd0, resp}, {30'd0, e.exp_resp});
      end
      OP_RD: begin
        bus_read(e.addr, rdata, resp);
        check_val($sformatf("rresp[%08h]", e.addr), {30'd0, resp}, {30'd0, e.exp_resp});
        check_val($sformatf("rdata[%08h]", e.addr), rdata, e.exp_data);
      end
      OP_BOOT: begin
        // one cycle bootloader request
        bootloader = 1'b1;
        next_slot();
        bootloader = 1'b0;
      end
      OP_RSTA: begin
        @(negedge clk);
        check_val("rst_addr_o", rst_addr, e.exp_data);
        next_slot();
      end
      OP_CSR: begin
        @(negedge clk);
        check_val("csr_o", {24'd0, csr}, e.exp_data);
        next_slot();
      end
      default: begin
        err_cnt++;
        $display("ERROR: stimulus table holds an unknown operation %0d", e.op);
      end
    endcase
  endtask

  // watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: run timed out after %0d cycles before the table was done", cycle_cnt);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    rst_n_i    = 1'b0;
    bootloader = 1'b0;
    m_req      = '0;
    err_cnt    = 0;
    check_cnt  = 0;
    lcg_state  = 32'hf9ddc24e;
    load_table();
    repeat (8) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    for (int i = 0; i < n_loaded; i++) begin
      apply_entry(stim[i]);
    end
    next_slot();
    $display("checks: %0d  value errors: %0d  assertion failures: %0d",
             check_cnt, err_cnt, dut0.chk0.assert_fails);
    if (err_cnt == 0 && dut0.chk0.assert_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
